//--- design/hpm_pkg.sv
/*
 * shared widths and constants for the performance monitor
 * RV32 only: 64-bit counters are reached as low and high CSR halves
 * event index i always feeds counter i, there are no mhpmevent selectors
 * impl_mask() gives the counters that exist for a given NUM_HPM (1 to 10)
 */
`default_nettype none

package hpm_pkg;

    localparam int unsigned XLEN         = 32;
    localparam int unsigned CNT_W        = 64;
    localparam int unsigned MAX_COUNTERS = 32; // size of the CSR address window

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [CNT_W-1:0]        counter_t;
    typedef logic [11:0]             csr_addr_t;
    typedef logic [1:0]              priv_level_t;
    typedef logic [MAX_COUNTERS-1:0] hpm_events_t;

    // privilege levels
    localparam priv_level_t PRIV_U = 2'd0;
    localparam priv_level_t PRIV_S = 2'd1;
    localparam priv_level_t PRIV_M = 2'd3;

    // fixed event slots
    localparam int unsigned EV_CYCLE       = 0;
    localparam int unsigned EV_TIME        = 1; // never counts here
    localparam int unsigned EV_INSTRET     = 2;
    localparam int unsigned EV_HPM_BASE    = 3;
    localparam int unsigned EV_ICACHE_MISS = 3;
    localparam int unsigned EV_DCACHE_MISS = 4;
    localparam int unsigned EV_ICACHE_HIT  = 5;
    localparam int unsigned EV_DCACHE_HIT  = 6;
    localparam int unsigned EV_ITLB_MISS   = 7;
    localparam int unsigned EV_DTLB_MISS   = 8;
    localparam int unsigned EV_ITLB_HIT    = 9;
    localparam int unsigned EV_DTLB_HIT    = 10;
    localparam int unsigned EV_MEM_STALL   = 11;
    localparam int unsigned EV_BUS_BUSY    = 12;

    // CSR addresses, each counter window is 32 entries wide
    localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
    localparam csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;
    localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t CSR_CYCLE         = 12'hC00;
    localparam csr_addr_t CSR_CYCLEH        = 12'hC80;
    localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t CSR_MCOUNTEREN    = 12'h306;

    // one bit per counter that is backed by storage
    function automatic hpm_events_t impl_mask(input int unsigned num_hpm);
        hpm_events_t m;
        m = '0;
        m[EV_CYCLE] = 1'b1;
        for (int unsigned i = EV_INSTRET; i < EV_HPM_BASE + num_hpm; i++) begin
            if (i < MAX_COUNTERS) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- design/hpm_event_sense.sv
/*
 * turns pipeline and cache status levels into one-cycle count events
 * all inputs are sampled on the rising edge, events come out of flops
 * miss events fire on the falling edge of the miss line, so a miss that
 * lasts several cycles counts once
 * bit 0 (cycle) is constant 1, bit 1 (time) is never set
 */
`default_nettype none

module hpm_event_sense
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_HPM = 10
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        icache_miss,
    input  logic        dcache_miss,
    input  logic        itlb_miss,
    input  logic        dtlb_miss,
    input  logic        icache_hit,
    input  logic        dcache_hit,
    input  logic        itlb_hit,
    input  logic        dtlb_hit,
    input  logic        iren,
    input  logic        dren,
    input  logic        dwen,
    input  logic        ex_mem_stall,
    input  logic        bus_busy,
    input  logic        wb_enable,
    input  logic        instr,
    output hpm_events_t events
);

    localparam hpm_events_t IMPL = impl_mask(NUM_HPM);

    // previous samples of the miss lines
    logic icache_miss_q;
    logic dcache_miss_q;
    logic itlb_miss_q;
    logic dtlb_miss_q;

    logic icache_miss_fall;
    logic dcache_miss_fall;
    logic itlb_miss_fall;
    logic dtlb_miss_fall;
    logic dacc_en;
    logic no_stall;

    hpm_events_t ev_next;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            icache_miss_q <= 1'b0;
            dcache_miss_q <= 1'b0;
            itlb_miss_q   <= 1'b0;
            dtlb_miss_q   <= 1'b0;
        end else begin
            icache_miss_q <= icache_miss;
            dcache_miss_q <= dcache_miss;
            itlb_miss_q   <= itlb_miss;
            dtlb_miss_q   <= dtlb_miss;
        end
    end

    // 1 -> 0 on the miss line
    assign icache_miss_fall = icache_miss_q & ~icache_miss;
    assign dcache_miss_fall = dcache_miss_q & ~dcache_miss;
    assign itlb_miss_fall   = itlb_miss_q & ~itlb_miss;
    assign dtlb_miss_fall   = dtlb_miss_q & ~dtlb_miss;

    assign dacc_en  = dren | dwen; // any data access
    assign no_stall = ~ex_mem_stall;

    always_comb begin
        ev_next = '0;
        ev_next[EV_CYCLE]       = 1'b1;
        ev_next[EV_INSTRET]     = wb_enable & instr;
        ev_next[EV_ICACHE_MISS] = icache_miss_fall;
        ev_next[EV_DCACHE_MISS] = dcache_miss_fall;
        ev_next[EV_ICACHE_HIT]  = iren & icache_hit & no_stall;
        ev_next[EV_DCACHE_HIT]  = dacc_en & dcache_hit & no_stall;
        ev_next[EV_ITLB_MISS]   = iren & itlb_miss_fall;    // gated by fetch
        ev_next[EV_DTLB_MISS]   = dacc_en & dtlb_miss_fall; // gated by load/store
        ev_next[EV_ITLB_HIT]    = itlb_hit;
        ev_next[EV_DTLB_HIT]    = dtlb_hit;
        ev_next[EV_MEM_STALL]   = ex_mem_stall;
        ev_next[EV_BUS_BUSY]    = bus_busy;
    end

    // drop events of counters that are not built
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            events <= hpm_events_t'(1) << EV_CYCLE;
        end else begin
            events <= ev_next & IMPL;
        end
    end

endmodule

`default_nettype wire

//--- design/hpm_counter_bank.sv
/*
 * 64-bit counter storage, one counter per event index
 * only cycle, instret and mhpmcounter3 to 2+NUM_HPM have flops,
 * every other entry of counters reads zero
 * a half-word write wins over the increment of the same edge
 * inhibit is used as seen at the edge, no extra delay in here
 */
`default_nettype none

module hpm_counter_bank
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_HPM = 10
) (
    input  logic        CLK,
    input  logic        nRST,
    input  hpm_events_t events,
    input  hpm_events_t inhibit,
    input  logic        wr_en,
    input  logic [4:0]  wr_index,
    input  logic        wr_hi,
    input  xlen_t       wr_data,
    output counter_t    counters [0:MAX_COUNTERS-1]
);

    localparam hpm_events_t IMPL = impl_mask(NUM_HPM);

    hpm_events_t wr_sel_lo;
    hpm_events_t wr_sel_hi;
    hpm_events_t inc_en;

    // one-hot write select per half
    always_comb begin
        wr_sel_lo = '0;
        wr_sel_hi = '0;
        if (wr_en) begin
            if (wr_hi) begin
                wr_sel_hi[wr_index] = 1'b1;
            end else begin
                wr_sel_lo[wr_index] = 1'b1;
            end
        end
    end

    assign inc_en = events & ~inhibit & IMPL;

    for (genvar i = 0; i < MAX_COUNTERS; i++) begin : g_ctr
        if (IMPL[i]) begin : g_impl
            counter_t cnt;

            always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                    cnt <= '0;
                end else if (wr_sel_hi[i]) begin
                    cnt[CNT_W-1:XLEN] <= wr_data; // low half holds, no increment
                end else if (wr_sel_lo[i]) begin
                    cnt[XLEN-1:0] <= wr_data;
                end else if (inc_en[i]) begin
                    cnt <= cnt + counter_t'(1);
                end
            end

            assign counters[i] = cnt;
        end else begin : g_none
            // unbuilt slot, also covers the time index
            assign counters[i] = '0;
        end
    end

endmodule

`default_nettype wire

//--- design/hpm_csr_access.sv
/*
 * Zicsr style access to the counters, mcountinhibit and mcounteren
 * csr_req is a one-cycle strobe, rdata and invalid answer in the same cycle
 * writes land on the next rising edge, there is no back-pressure
 * machine addresses need M mode, user shadows are read-only and need
 * mcounteren below M, anything else is invalid and reads 0
 * bit 1 of mcountinhibit is hardwired to 0
 */
`default_nettype none

module hpm_csr_access
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_HPM = 10
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        csr_req,
    input  csr_addr_t   csr_addr,
    input  logic        csr_swap,
    input  logic        csr_set,
    input  logic        csr_clear,
    input  logic        csr_read_only,
    input  xlen_t       csr_wdata,
    input  priv_level_t priv,
    input  counter_t    counters [0:MAX_COUNTERS-1],
    output xlen_t       csr_rdata,
    output logic        csr_invalid,
    output hpm_events_t inhibit,
    output logic        wr_en,
    output logic [4:0]  wr_index,
    output logic        wr_hi,
    output xlen_t       wr_data
);

    localparam hpm_events_t IMPL     = impl_mask(NUM_HPM);
    localparam hpm_events_t INH_MASK = ~(hpm_events_t'(1) << EV_TIME);

    // upper seven address bits select a 32-entry window
    localparam logic [6:0] WIN_M_LO = CSR_MCYCLE[11:5];
    localparam logic [6:0] WIN_M_HI = CSR_MCYCLEH[11:5];
    localparam logic [6:0] WIN_U_LO = CSR_CYCLE[11:5];
    localparam logic [6:0] WIN_U_HI = CSR_CYCLEH[11:5];

    hpm_events_t inhibit_q;
    hpm_events_t counteren_q;

    logic [4:0] idx;
    logic       in_mctr;
    logic       in_uctr;
    logic       hi_half;
    logic       is_inh;
    logic       is_en;
    logic       is_m;
    logic       do_write;
    logic       valid;
    counter_t   sel_ctr;
    xlen_t      old_val;
    xlen_t      new_val;

    // address decode
    always_comb begin
        idx     = csr_addr[4:0];
        in_mctr = (csr_addr[11:5] == WIN_M_LO) || (csr_addr[11:5] == WIN_M_HI);
        in_uctr = (csr_addr[11:5] == WIN_U_LO) || (csr_addr[11:5] == WIN_U_HI);
        hi_half = (csr_addr[11:5] == WIN_M_HI) || (csr_addr[11:5] == WIN_U_HI);
        is_inh  = (csr_addr == CSR_MCOUNTINHIBIT);
        is_en   = (csr_addr == CSR_MCOUNTEREN);
    end

    assign is_m     = (priv == PRIV_M);
    assign do_write = ~csr_read_only & (csr_swap | csr_set | csr_clear);

    // privilege rule, shadows never take a write
    assign valid = ((in_mctr | is_inh | is_en) & is_m)
                 | (in_uctr & ~do_write & (is_m | counteren_q[idx]));

    // old value mux
    always_comb begin
        sel_ctr = counters[idx];
        old_val = '0;
        if (in_mctr || in_uctr) begin
            old_val = hi_half ? sel_ctr[CNT_W-1:XLEN] : sel_ctr[XLEN-1:0];
        end else if (is_inh) begin
            old_val = inhibit_q;
        end else if (is_en) begin
            old_val = counteren_q;
        end
    end

    always_comb begin
        if (csr_swap) begin
            new_val = csr_wdata;
        end else if (csr_set) begin
            new_val = old_val | csr_wdata;
        end else if (csr_clear) begin
            new_val = old_val & ~csr_wdata;
        end else begin
            new_val = old_val;
        end
    end

    assign csr_rdata   = (csr_req && valid) ? old_val : '0;
    assign csr_invalid = csr_req & ~valid;

    // bank write strobe, unbuilt counters simply drop it
    assign wr_en    = csr_req & valid & do_write & in_mctr & IMPL[idx];
    assign wr_index = idx;
    assign wr_hi    = hi_half;
    assign wr_data  = new_val;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            inhibit_q   <= '0;
            counteren_q <= '0;
        end else if (csr_req && valid && do_write) begin
            if (is_inh) begin
                inhibit_q <= new_val & INH_MASK;
            end
            if (is_en) begin
                counteren_q <= new_val;
            end
        end
    end

    assign inhibit = inhibit_q; // takes effect one edge after the write

endmodule

`default_nettype wire

//--- design/hpm_unit.sv
/*
 * performance monitor top: event sensing, counter bank, CSR access
 * NUM_HPM programmable counters (1 to 10) sit at indices 3 and up
 * a status level reaches a counter read two rising edges after it is driven
 * no traps, interrupts or overflow handling
 */
`default_nettype none

module hpm_unit
    import hpm_pkg::*;
#(
    parameter int unsigned NUM_HPM = 10
) (
    input  logic        CLK,
    input  logic        nRST,
    // pipeline and cache status
    input  logic        icache_miss,
    input  logic        dcache_miss,
    input  logic        itlb_miss,
    input  logic        dtlb_miss,
    input  logic        icache_hit,
    input  logic        dcache_hit,
    input  logic        itlb_hit,
    input  logic        dtlb_hit,
    input  logic        iren,
    input  logic        dren,
    input  logic        dwen,
    input  logic        ex_mem_stall,
    input  logic        bus_busy,
    input  logic        wb_enable,
    input  logic        instr,
    // CSR request
    input  logic        csr_req,
    input  csr_addr_t   csr_addr,
    input  logic        csr_swap,
    input  logic        csr_set,
    input  logic        csr_clear,
    input  logic        csr_read_only,
    input  xlen_t       csr_wdata,
    input  priv_level_t priv,
    output xlen_t       csr_rdata,
    output logic        csr_invalid
);

    hpm_events_t events;
    hpm_events_t inhibit;
    counter_t    counters [0:MAX_COUNTERS-1];
    logic        wr_en;
    logic [4:0]  wr_index;
    logic        wr_hi;
    xlen_t       wr_data;

    hpm_event_sense #(.NUM_HPM(NUM_HPM)) event_sense (
        .CLK(CLK), .nRST(nRST),
        .icache_miss(icache_miss), .dcache_miss(dcache_miss),
        .itlb_miss(itlb_miss), .dtlb_miss(dtlb_miss),
        .icache_hit(icache_hit), .dcache_hit(dcache_hit),
        .itlb_hit(itlb_hit), .dtlb_hit(dtlb_hit),
        .iren(iren), .dren(dren), .dwen(dwen),
        .ex_mem_stall(ex_mem_stall), .bus_busy(bus_busy),
        .wb_enable(wb_enable), .instr(instr),
        .events(events)
    );

    hpm_counter_bank #(.NUM_HPM(NUM_HPM)) counter_bank (
        .CLK(CLK), .nRST(nRST),
        .events(events), .inhibit(inhibit),
        .wr_en(wr_en), .wr_index(wr_index), .wr_hi(wr_hi), .wr_data(wr_data),
        .counters(counters)
    );

    hpm_csr_access #(.NUM_HPM(NUM_HPM)) csr_access (
        .CLK(CLK), .nRST(nRST),
        .csr_req(csr_req), .csr_addr(csr_addr),
        .csr_swap(csr_swap), .csr_set(csr_set), .csr_clear(csr_clear),
        .csr_read_only(csr_read_only), .csr_wdata(csr_wdata), .priv(priv),
        .counters(counters),
        .csr_rdata(csr_rdata), .csr_invalid(csr_invalid),
        .inhibit(inhibit),
        .wr_en(wr_en), .wr_index(wr_index), .wr_hi(wr_hi), .wr_data(wr_data)
    );

endmodule

`default_nettype wire

//--- bench/hpm_unit_tb.sv
/*
 * directed testbench for hpm_unit with NUM_HPM = 10
 * CSR answers are sampled on the falling edge inside the request cycle
 * edge distances are taken from simulation time, 20 ns per clock
 * status inputs stay idle outside the event test, so only mcycle moves
 */
`default_nettype none

module hpm_unit_tb
    import hpm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD  = 20;
    localparam int unsigned TEST_COUNT  = 6;
    localparam int unsigned WATCHDOG_NS = TEST_COUNT * 2000 * CLK_PERIOD;
    localparam logic [3:0]  OP_SWAP     = 4'b0001;
    localparam logic [3:0]  OP_SET      = 4'b0010;
    localparam logic [3:0]  OP_CLR      = 4'b0100;
    localparam logic [3:0]  OP_RD       = 4'b1000;

    logic        CLK, nRST;
    logic        icache_miss, dcache_miss, itlb_miss, dtlb_miss;
    logic        icache_hit, dcache_hit, itlb_hit, dtlb_hit;
    logic        iren, dren, dwen, ex_mem_stall, bus_busy, wb_enable, instr;
    logic        csr_req, csr_swap, csr_set, csr_clear, csr_read_only;
    csr_addr_t   csr_addr;
    xlen_t       csr_wdata;
    priv_level_t priv;
    xlen_t       csr_rdata;
    logic        csr_invalid;

    int unsigned err_count   = 0;
    int unsigned check_count = 0;
    time         release_time;
    time         req_time; // edge that raised the last request
    time         wr_time;  // edge that closed it, writes land here

    hpm_unit #(.NUM_HPM(10)) UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic check(input string name, input counter_t actual, input counter_t expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic end_test(input string name, input int unsigned start);
        if (err_count == start) begin
            $display("%s: done, no errors", name);
        end else begin
            $display("%s: done, %0d errors", name, err_count - start);
        end
    endtask

    // one strobe, answer sampled mid-cycle
    task automatic csr_access(input csr_addr_t addr, input logic [3:0] op, input xlen_t wdata,
                              input priv_level_t lvl, output xlen_t rdata, output logic inv);
        @(posedge CLK);
        csr_req       <= 1'b1;
        csr_addr      <= addr;
        {csr_read_only, csr_clear, csr_set, csr_swap} <= op;
        csr_wdata     <= wdata;
        priv          <= lvl;
        req_time = $time;
        @(negedge CLK);
        rdata = csr_rdata;
        inv   = csr_invalid;
        @(posedge CLK);
        wr_time = $time;
        csr_req <= 1'b0;
        {csr_read_only, csr_clear, csr_set, csr_swap} <= 4'b0000;
    endtask

    task automatic read_counter(input int unsigned idx, output counter_t value);
        xlen_t lo, hi;
        logic  inv_lo, inv_hi;
        csr_access(CSR_MCYCLE + csr_addr_t'(idx), OP_RD, '0, PRIV_M, lo, inv_lo);
        csr_access(CSR_MCYCLEH + csr_addr_t'(idx), OP_RD, '0, PRIV_M, hi, inv_hi);
        check("csr_invalid", 64'(inv_lo | inv_hi), 64'(0));
        value = {hi, lo};
    endtask

    // swap, set and clear rules, read only leaves the value alone
    function automatic xlen_t next_csr_value(input xlen_t old, input logic [3:0] op,
                                             input xlen_t wdata);
        if (op[3]) return old;
        if (op[0]) return wdata;
        if (op[1]) return old | wdata;
        if (op[2]) return old & ~wdata;
        return old;
    endfunction

    task automatic op_check(input string name, input csr_addr_t addr, input logic [3:0] op,
                            input xlen_t wdata, input xlen_t keep_mask);
        xlen_t old, rd, now;
        logic  inv;
        csr_access(addr, OP_RD, '0, PRIV_M, old, inv);
        csr_access(addr, op, wdata, PRIV_M, rd, inv);
        check({name, " old value"}, 64'(rd), 64'(old));
        check("csr_invalid", 64'(inv), 64'(0));
        csr_access(addr, OP_RD, '0, PRIV_M, now, inv);
        check(name, 64'(now), 64'(next_csr_value(old, op, wdata) & keep_mask));
    endtask

    task automatic test_reset();
        int unsigned start;
        counter_t    got;
        xlen_t       rd;
        logic        inv;
        start = err_count;
        @(negedge CLK);
        check("csr_invalid", 64'(csr_invalid), 64'(0)); // no request yet
        csr_access(CSR_MCYCLE, OP_RD, '0, PRIV_M, rd, inv);
        check("csr_invalid", 64'(inv), 64'(0));
        // cycle runs from the first edge after reset release
        check("mcycle", 64'(rd), 64'((req_time - release_time) / CLK_PERIOD));
        @(negedge CLK);
        check("csr_rdata", 64'(csr_rdata), 64'(0)); // idle, address still on mcycle
        csr_access(CSR_MCYCLEH, OP_RD, '0, PRIV_M, rd, inv);
        check("csr_invalid", 64'(inv), 64'(0));
        check("mcycleh", 64'(rd), 64'(0));
        for (int i = 1; i < 32; i++) begin
            read_counter(i, got);
            check($sformatf("counter%0d", i), got, 64'(0));
        end
        csr_access(CSR_MCOUNTINHIBIT, OP_RD, '0, PRIV_M, rd, inv);
        check("csr_invalid", 64'(inv), 64'(0));
        check("mcountinhibit", 64'(rd), 64'(0));
        csr_access(CSR_MCOUNTEREN, OP_RD, '0, PRIV_M, rd, inv);
        check("csr_invalid", 64'(inv), 64'(0));
        check("mcounteren", 64'(rd), 64'(0));
        end_test("reset state", start);
    endtask

    task automatic test_inhibit();
        int unsigned start, gap;
        counter_t    value, got;
        time         t_a, t_b;
        xlen_t       rd;
        logic        inv;
        start = err_count;
        value = {$urandom, $urandom};
        gap   = 5 + $urandom % 40;
        csr_access(CSR_MCOUNTINHIBIT, OP_SWAP, '1, PRIV_M, rd, inv);
        csr_access(CSR_MCYCLE, OP_SWAP, value[31:0], PRIV_M, rd, inv);
        csr_access(CSR_MCYCLEH, OP_SWAP, value[63:32], PRIV_M, rd, inv);
        read_counter(0, got);
        check("mcycle", got, value);
        csr_access(CSR_MCOUNTINHIBIT, OP_SWAP, '0, PRIV_M, rd, inv);
        t_a = wr_time;
        repeat (gap) @(posedge CLK);
        csr_access(CSR_MCOUNTINHIBIT, OP_SWAP, '1, PRIV_M, rd, inv);
        t_b = wr_time;
        read_counter(0, got);
        check("mcycle", got, value + counter_t'((t_b - t_a) / CLK_PERIOD));
        end_test("cycle under inhibit", start);
    endtask

    task automatic test_events();
        int unsigned start, n_miss, len, k, s, nf, gated, nw, overlaps;
        logic        a, b;
        counter_t    got;
        xlen_t       rd;
        logic        inv;
        start = err_count;
        csr_access(CSR_MCOUNTINHIBIT, OP_SWAP, '0, PRIV_M, rd, inv);
        for (int i = 2; i <= 12; i++) begin
            csr_access(CSR_MCYCLE + csr_addr_t'(i), OP_SWAP, '0, PRIV_M, rd, inv);
        end
        n_miss = 3 + $urandom % 8;
        for (int p = 0; p < n_miss; p++) begin
            len = 1 + $urandom % 3;
            repeat (len) begin
                @(posedge CLK);
                icache_miss <= 1'b1;
            end
            @(posedge CLK);
            icache_miss <= 1'b0; // one fall per pulse
        end
        k = 4 + $urandom % 12;
        s = 0;
        for (int c = 0; c < k; c++) begin
            a = 1'($urandom);
            if (a) s++;
            @(posedge CLK);
            {dcache_hit, dren, ex_mem_stall} <= {1'b1, 1'b1, a};
        end
        @(posedge CLK);
        {dcache_hit, dren, ex_mem_stall} <= 3'b000;
        nf    = 6 + $urandom % 6;
        gated = 0;
        for (int f = 0; f < nf; f++) begin
            a = 1'($urandom);
            if (a) gated++;
            @(posedge CLK);
            itlb_miss <= 1'b1;
            @(posedge CLK);
            itlb_miss <= 1'b0;
            iren      <= a; // fetch enable at the falling sample
            @(posedge CLK);
            iren <= 1'b0;
        end
        nw       = 10 + $urandom % 20;
        overlaps = 0;
        for (int w = 0; w < nw; w++) begin
            a = 1'($urandom);
            b = 1'($urandom);
            if (a && b) overlaps++;
            @(posedge CLK);
            {wb_enable, instr} <= {a, b};
        end
        @(posedge CLK);
        {wb_enable, instr} <= 2'b00;
        repeat (2) @(posedge CLK); // last events still in flight
        read_counter(EV_ICACHE_MISS, got);
        check("mhpmcounter3", got, 64'(n_miss));
        read_counter(EV_DCACHE_HIT, got);
        check("mhpmcounter6", got, 64'(k - s));
        read_counter(EV_MEM_STALL, got);
        check("mhpmcounter11", got, 64'(s));
        read_counter(EV_ITLB_MISS, got);
        check("mhpmcounter7", got, 64'(gated));
        read_counter(EV_INSTRET, got);
        check("minstret", got, 64'(overlaps));
        end_test("event rules", start);
    endtask

    task automatic test_ops();
        int unsigned start;
        csr_addr_t   addrs [3];
        xlen_t       masks [3];
        string       names [3];
        logic [3:0]  ops [4];
        start = err_count;
        addrs = '{CSR_MCYCLEH + 12'd5, CSR_MCOUNTEREN, CSR_MCOUNTINHIBIT};
        masks = '{'1, '1, ~32'h2}; // inhibit bit 1 is hardwired low
        names = '{"mhpmcounter5h", "mcounteren", "mcountinhibit"};
        ops   = '{OP_SWAP, OP_SET, OP_CLR, OP_RD | OP_SWAP};
        for (int r = 0; r < 3; r++) begin
            for (int o = 0; o < 4; o++) begin
                op_check(names[r], addrs[r], ops[o], $urandom | 32'h2, masks[r]);
            end
        end
        end_test("set clear swap", start);
    endtask

    task automatic test_priv();
        int unsigned start;
        xlen_t       m_cycle, rd;
        logic        inv;
        priv_level_t levels [3];
        start  = err_count;
        levels = '{PRIV_U, PRIV_S, PRIV_M};
        csr_access(CSR_MCOUNTINHIBIT, OP_SWAP, '1, PRIV_M, rd, inv); // freeze all counters
        csr_access(CSR_MCOUNTEREN, OP_SWAP, '0, PRIV_M, rd, inv);
        csr_access(CSR_MCYCLE, OP_RD, '0, PRIV_M, m_cycle, inv);
        csr_access(CSR_CYCLE, OP_RD, '0, PRIV_U, rd, inv);
        check("csr_invalid", 64'(inv), 64'(1));
        check("csr_rdata", 64'(rd), 64'(0));
        csr_access(CSR_MCOUNTEREN, OP_SWAP, 32'h1, PRIV_M, rd, inv);
        csr_access(CSR_CYCLE, OP_RD, '0, PRIV_U, rd, inv);
        check("csr_invalid", 64'(inv), 64'(0));
        check("cycle", 64'(rd), 64'(m_cycle));
        csr_access(CSR_MCYCLE, OP_SWAP, $urandom, PRIV_U, rd, inv);
        check("csr_invalid", 64'(inv), 64'(1));
        for (int l = 0; l < 3; l++) begin
            csr_access(CSR_CYCLE, OP_SWAP, $urandom, levels[l], rd, inv);
            check("csr_invalid", 64'(inv), 64'(1)); // shadows are read only
        end
        csr_access(CSR_MCYCLE, OP_RD, '0, PRIV_M, rd, inv);
        check("mcycle", 64'(rd), 64'(m_cycle));
        end_test("privilege", start);
    endtask

    task automatic test_unimpl();
        int unsigned start;
        counter_t    got;
        xlen_t       rd;
        logic        inv;
        start = err_count;
        for (int i = 13; i < 32; i++) begin
            csr_access(CSR_MCYCLE + csr_addr_t'(i), OP_SWAP, $urandom, PRIV_M, rd, inv);
            check("csr_rdata", 64'(rd), 64'(0));
            csr_access(CSR_MCYCLEH + csr_addr_t'(i), OP_SWAP, $urandom, PRIV_M, rd, inv);
            check("csr_rdata", 64'(rd), 64'(0));
            read_counter(i, got);
            check($sformatf("mhpmcounter%0d", i), got, 64'(0));
        end
        csr_access(12'hB01, OP_RD, '0, PRIV_M, rd, inv); // time slot
        check("csr_rdata", 64'(rd), 64'(0));
        csr_access(12'h7C0, OP_RD, '0, PRIV_M, rd, inv);
        check("csr_invalid", 64'(inv), 64'(1));
        check("csr_rdata", 64'(rd), 64'(0));
        end_test("unknown addresses", start);
    endtask

    initial begin
        void'($urandom(32'hded6cb0d));
        nRST <= 1'b0;
        {icache_miss, dcache_miss, itlb_miss, dtlb_miss} <= 4'b0000;
        {icache_hit, dcache_hit, itlb_hit, dtlb_hit}     <= 4'b0000;
        {iren, dren, dwen, ex_mem_stall, bus_busy}       <= 5'b00000;
        {wb_enable, instr}                               <= 2'b00;
        {csr_req, csr_swap, csr_set, csr_clear, csr_read_only} <= 5'b00000;
        csr_addr  <= '0;
        csr_wdata <= '0;
        priv      <= PRIV_M;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        release_time = $time;
        test_reset();
        test_inhibit();
        test_events();
        test_ops();
        test_priv();
        test_unimpl();
        $display("tests %0d, checks %0d, errors %0d", TEST_COUNT, check_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hpm_unit.f
design/hpm_pkg.sv
design/hpm_event_sense.sv
design/hpm_counter_bank.sv
design/hpm_csr_access.sv
design/hpm_unit.sv
bench/hpm_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the hpm_unit testbench with Verilator and runs it
# the run passes only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module hpm_unit_tb -f hpm_unit.f -o hpm_unit_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/hpm_unit_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && { echo "simulation ok"; exit 0; } \
    || { echo "simulation did not pass"; exit 1; }
